/* files.f */
+incdir+include
src/bp_pkg.sv
src/bht.sv
src/btb.sv
src/rollback_arbiter.sv
src/fetch_predict.sv
src/bp_top.sv
test/tb_bp.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps \
  -f files.f --top-module tb_bp \
  -Mdir obj_dir -o tb_bp_sim
./obj_dir/tb_bp_sim

/* src/bht.sv */
`timescale 1ns/1ps

module bht #(
  parameter int bh_idx_bits = 5
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [1:0][bh_idx_bits-1:0] rd_idx,
  input  logic [1:0]                  train_en,
  input  logic [1:0][bh_idx_bits-1:0] train_idx,
  input  logic [1:0]                  train_taken,
  output logic [1:0]                  pred_taken
);

  localparam int entries = 2 ** bh_idx_bits;

  logic [entries-1:0][1:0] ctr;
  logic [entries-1:0][1:0] ctr_next;

  // slot 1 is applied on top of slot 0
  always_comb begin
    ctr_next = ctr;
    for (int i = 0; i < 2; i++) begin
      if (train_en[i]) begin
        if (train_taken[i]) begin
          if (ctr_next[train_idx[i]] != 2'b11) begin
            ctr_next[train_idx[i]] = ctr_next[train_idx[i]] + 2'd1;
          end
        end else begin
          if (ctr_next[train_idx[i]] != 2'b00) begin
            ctr_next[train_idx[i]] = ctr_next[train_idx[i]] - 2'd1;
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ctr <= {entries{bp_pkg::bht_reset_val}};
    end else begin
      ctr <= ctr_next;
    end
  end

  // reads see this cycle's training
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      pred_taken[i] = ctr_next[rd_idx[i]][1];
    end
  end

endmodule

/* src/bp_pkg.sv */
package bp_pkg;

  typedef logic [63:0] pc_t;
  typedef logic [31:0] inst_t;
  typedef logic [5:0]  opcode_t;

  // conditional branches, all in the 0x38..0x3f block
  localparam opcode_t blbc_op = 6'h38;
  localparam opcode_t beq_op  = 6'h39;
  localparam opcode_t blt_op  = 6'h3a;
  localparam opcode_t ble_op  = 6'h3b;
  localparam opcode_t blbs_op = 6'h3c;
  localparam opcode_t bne_op  = 6'h3d;
  localparam opcode_t bge_op  = 6'h3e;
  localparam opcode_t bgt_op  = 6'h3f;

  // always taken
  localparam opcode_t br_op      = 6'h30;
  localparam opcode_t bsr_op     = 6'h34;
  localparam opcode_t jsr_grp_op = 6'h1a; // jmp, jsr, ret, jsr_coroutine

  localparam logic [1:0] bht_reset_val = 2'b01; // weakly not taken
  localparam pc_t        btb_reset_val = '0;

  function automatic opcode_t opcode_of(inst_t inst);
    return inst[31:26];
  endfunction

  function automatic logic is_cond_branch(opcode_t op);
    case (op)
      blbc_op, beq_op, blt_op, ble_op,
      blbs_op, bne_op, bge_op, bgt_op: return 1'b1;
      default:                         return 1'b0;
    endcase
  endfunction

  function automatic logic is_uncond_branch(opcode_t op);
    case (op)
      br_op, bsr_op, jsr_grp_op: return 1'b1;
      default:                   return 1'b0;
    endcase
  endfunction

endpackage

/* src/bp_top.sv */
`timescale 1ns/1ps

module bp_top #(
  parameter int bh_idx_bits  = 5,
  parameter int rob_idx_bits = 5,
  parameter int fl_idx_bits  = 6,
  parameter int lsq_idx_bits = 3
) (
  input  logic                          clock,
  input  logic                          reset,
  input  bp_pkg::pc_t [1:0]             fetch_pc,
  input  bp_pkg::inst_t [1:0]           fetch_inst,
  input  logic [1:0]                    fetch_valid,
  input  bp_pkg::pc_t                   fetch_next_pc,
  input  logic [rob_idx_bits-1:0]       rob_tail_idx,
  input  logic [1:0]                    br_done,
  input  logic [1:0]                    br_taken,
  input  bp_pkg::pc_t [1:0]             br_pc,
  input  bp_pkg::pc_t [1:0]             br_pred_target,
  input  bp_pkg::pc_t [1:0]             br_target,
  input  logic [1:0][rob_idx_bits-1:0]  br_rob_idx,
  input  logic [1:0][fl_idx_bits-1:0]   br_fl_idx,
  input  logic [1:0][lsq_idx_bits-1:0]  br_sq_idx,
  input  logic [1:0][lsq_idx_bits-1:0]  br_lq_idx,
  input  logic [1:0]                    ld_violate,
  input  bp_pkg::pc_t [1:0]             ld_replay_pc,
  input  logic [1:0][rob_idx_bits-1:0]  ld_rob_idx,
  input  logic [1:0][fl_idx_bits-1:0]   ld_fl_idx,
  input  logic [1:0][lsq_idx_bits-1:0]  ld_sq_idx,
  input  logic [1:0][lsq_idx_bits-1:0]  ld_lq_idx,
  output logic                          rollback_en,
  output logic [rob_idx_bits-1:0]       rollback_rob_idx,
  output logic [fl_idx_bits-1:0]        rollback_fl_idx,
  output logic [lsq_idx_bits-1:0]       rollback_sq_idx,
  output logic [lsq_idx_bits-1:0]       rollback_lq_idx,
  output logic [1:0]                    take_branch,
  output bp_pkg::pc_t                   redirect_pc,
  output logic [1:0]                    slot_valid
);

  logic [1:0][bh_idx_bits-1:0] rd_idx;
  logic [1:0]                  pred_taken;
  bp_pkg::pc_t [1:0]           rd_target;
  bp_pkg::pc_t                 rollback_pc;
  logic [1:0]                  train_en;
  logic [1:0][bh_idx_bits-1:0] train_idx;
  logic [1:0]                  train_taken;
  logic                        btb_we;
  logic [bh_idx_bits-1:0]      btb_wr_idx;
  bp_pkg::pc_t                 btb_wr_target;

  bht #(.bh_idx_bits(bh_idx_bits)) u_bht (
    .clock, .reset, .rd_idx,
    .train_en, .train_idx, .train_taken,
    .pred_taken
  );

  btb #(.bh_idx_bits(bh_idx_bits)) u_btb (
    .clock, .reset, .rd_idx,
    .btb_we, .btb_wr_idx, .btb_wr_target,
    .rd_target
  );

  rollback_arbiter #(
    .bh_idx_bits  (bh_idx_bits),
    .rob_idx_bits (rob_idx_bits),
    .fl_idx_bits  (fl_idx_bits),
    .lsq_idx_bits (lsq_idx_bits)
  ) u_arb (
    .br_done, .br_taken, .br_pc, .br_pred_target, .br_target,
    .br_rob_idx, .br_fl_idx, .br_sq_idx, .br_lq_idx,
    .ld_violate, .ld_replay_pc,
    .ld_rob_idx, .ld_fl_idx, .ld_sq_idx, .ld_lq_idx,
    .rob_tail_idx,
    .rollback_en, .rollback_pc,
    .rollback_rob_idx, .rollback_fl_idx, .rollback_sq_idx, .rollback_lq_idx,
    .train_en, .train_idx, .train_taken,
    .btb_we, .btb_wr_idx, .btb_wr_target
  );

  fetch_predict #(.bh_idx_bits(bh_idx_bits)) u_fetch (
    .fetch_pc, .fetch_inst, .fetch_valid, .fetch_next_pc,
    .pred_taken, .rd_target,
    .rollback_en, .rollback_pc,
    .rd_idx, .take_branch, .redirect_pc, .slot_valid
  );

endmodule

/* src/btb.sv */
`timescale 1ns/1ps

module btb #(
  parameter int bh_idx_bits = 5
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [1:0][bh_idx_bits-1:0] rd_idx,
  input  logic                        btb_we,
  input  logic [bh_idx_bits-1:0]      btb_wr_idx,
  input  bp_pkg::pc_t                 btb_wr_target,
  output bp_pkg::pc_t [1:0]           rd_target
);

  localparam int entries = 2 ** bh_idx_bits;

  bp_pkg::pc_t [entries-1:0] tgt;

  always_ff @(posedge clock) begin
    if (reset) begin
      tgt <= {entries{bp_pkg::btb_reset_val}};
    end else if (btb_we) begin
      tgt[btb_wr_idx] <= btb_wr_target;
    end
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      if (btb_we && btb_wr_idx == rd_idx[i]) begin
        rd_target[i] = btb_wr_target; // write bypass
      end else begin
        rd_target[i] = tgt[rd_idx[i]];
      end
    end
  end

endmodule

/* src/fetch_predict.sv */
`timescale 1ns/1ps

module fetch_predict #(
  parameter int bh_idx_bits = 5
) (
  input  bp_pkg::pc_t [1:0]           fetch_pc,
  input  bp_pkg::inst_t [1:0]         fetch_inst,
  input  logic [1:0]                  fetch_valid,
  input  bp_pkg::pc_t                 fetch_next_pc,
  input  logic [1:0]                  pred_taken,
  input  bp_pkg::pc_t [1:0]           rd_target,
  input  logic                        rollback_en,
  input  bp_pkg::pc_t                 rollback_pc,
  output logic [1:0][bh_idx_bits-1:0] rd_idx,
  output logic [1:0]                  take_branch,
  output bp_pkg::pc_t                 redirect_pc,
  output logic [1:0]                  slot_valid
);

  bp_pkg::opcode_t [1:0] opcode;
  logic [1:0]            is_cond;
  logic [1:0]            is_uncond;
  logic [1:0]            pred;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      opcode[i]    = bp_pkg::opcode_of(fetch_inst[i]);
      is_cond[i]   = fetch_valid[i] && bp_pkg::is_cond_branch(opcode[i]);
      is_uncond[i] = fetch_valid[i] && bp_pkg::is_uncond_branch(opcode[i]);
      rd_idx[i]    = fetch_pc[i][bh_idx_bits+1:2]; // word index
    end
  end

  // taken when unconditional, or counter high bit set
  assign pred[0] = is_uncond[0] || (is_cond[0] && pred_taken[0]);
  assign pred[1] = is_uncond[1] || (is_cond[1] && pred_taken[1]);

  assign take_branch[0] = rollback_en || pred[0];
  assign take_branch[1] = rollback_en || pred[1];

  // slot 1 is dropped behind a taken slot 0
  assign slot_valid[0] = !rollback_en && fetch_valid[0];
  assign slot_valid[1] = !rollback_en && fetch_valid[1] && !pred[0];

  always_comb begin
    if (rollback_en) begin
      redirect_pc = rollback_pc;
    end else if (pred[0]) begin
      redirect_pc = rd_target[0];
    end else if (pred[1]) begin
      redirect_pc = rd_target[1];
    end else begin
      redirect_pc = fetch_next_pc; // fall through
    end
  end

endmodule

/* src/rollback_arbiter.sv */
`timescale 1ns/1ps

module rollback_arbiter #(
  parameter int bh_idx_bits  = 5,
  parameter int rob_idx_bits = 5,
  parameter int fl_idx_bits  = 6,
  parameter int lsq_idx_bits = 3
) (
  input  logic [1:0]                    br_done,
  input  logic [1:0]                    br_taken,
  input  bp_pkg::pc_t [1:0]             br_pc,
  input  bp_pkg::pc_t [1:0]             br_pred_target,
  input  bp_pkg::pc_t [1:0]             br_target,
  input  logic [1:0][rob_idx_bits-1:0]  br_rob_idx,
  input  logic [1:0][fl_idx_bits-1:0]   br_fl_idx,
  input  logic [1:0][lsq_idx_bits-1:0]  br_sq_idx,
  input  logic [1:0][lsq_idx_bits-1:0]  br_lq_idx,
  input  logic [1:0]                    ld_violate,
  input  bp_pkg::pc_t [1:0]             ld_replay_pc,
  input  logic [1:0][rob_idx_bits-1:0]  ld_rob_idx,
  input  logic [1:0][fl_idx_bits-1:0]   ld_fl_idx,
  input  logic [1:0][lsq_idx_bits-1:0]  ld_sq_idx,
  input  logic [1:0][lsq_idx_bits-1:0]  ld_lq_idx,
  input  logic [rob_idx_bits-1:0]       rob_tail_idx,
  output logic                          rollback_en,
  output bp_pkg::pc_t                   rollback_pc,
  output logic [rob_idx_bits-1:0]       rollback_rob_idx,
  output logic [fl_idx_bits-1:0]        rollback_fl_idx,
  output logic [lsq_idx_bits-1:0]       rollback_sq_idx,
  output logic [lsq_idx_bits-1:0]       rollback_lq_idx,
  output logic [1:0]                    train_en,
  output logic [1:0][bh_idx_bits-1:0]   train_idx,
  output logic [1:0]                    train_taken,
  output logic                          btb_we,
  output logic [bh_idx_bits-1:0]        btb_wr_idx,
  output bp_pkg::pc_t                   btb_wr_target
);

  bp_pkg::pc_t [1:0]             br_next_pc;
  logic [1:0]                    mispred;
  logic [1:0][rob_idx_bits-1:0]  br_dist;
  logic [1:0][rob_idx_bits-1:0]  ld_dist;
  logic                          br_any;
  logic                          ld_any;
  logic                          br_sel;
  logic                          ld_sel;
  logic                          br_wins;
  logic                          ld_wins;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      br_next_pc[i] = br_taken[i] ? br_target[i] : br_pc[i] + 64'd4;
      mispred[i]    = br_done[i] && (br_next_pc[i] != br_pred_target[i]);
      // distance back from the youngest entry, wraps with the ROB
      br_dist[i]    = rob_tail_idx - br_rob_idx[i];
      ld_dist[i]    = rob_tail_idx - ld_rob_idx[i];
    end
  end

  assign br_any = |mispred;
  assign ld_any = |ld_violate;

  // slot 1 only wins when strictly older
  assign br_sel = mispred[1] && (!mispred[0] || br_dist[1] > br_dist[0]);
  assign ld_sel = ld_violate[1] && (!ld_violate[0] || ld_dist[1] > ld_dist[0]);

  assign br_wins = br_any && (!ld_any || br_dist[br_sel] >= ld_dist[ld_sel]);
  assign ld_wins = ld_any && !br_wins;

  assign rollback_en = br_any || ld_any;

  always_comb begin
    rollback_pc      = '0;
    rollback_rob_idx = '0;
    rollback_fl_idx  = '0;
    rollback_sq_idx  = '0;
    rollback_lq_idx  = '0;
    if (br_wins) begin
      rollback_pc      = br_next_pc[br_sel];
      rollback_rob_idx = br_rob_idx[br_sel];
      rollback_fl_idx  = br_fl_idx[br_sel];
      rollback_sq_idx  = br_sq_idx[br_sel];
      rollback_lq_idx  = br_lq_idx[br_sel];
    end else if (ld_wins) begin
      rollback_pc      = ld_replay_pc[ld_sel];
      rollback_rob_idx = ld_rob_idx[ld_sel];
      rollback_fl_idx  = ld_fl_idx[ld_sel];
      rollback_sq_idx  = ld_sq_idx[ld_sel];
      rollback_lq_idx  = ld_lq_idx[ld_sel];
    end
  end

  // a winning load squashes the branches too, so no training then
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      train_en[i]    = br_done[i] && !ld_wins;
      train_idx[i]   = br_pc[i][bh_idx_bits+1:2];
      train_taken[i] = br_taken[i];
    end
  end

  assign btb_we        = br_wins && br_taken[br_sel];
  assign btb_wr_idx    = br_pc[br_sel][bh_idx_bits+1:2];
  assign btb_wr_target = br_target[br_sel];

endmodule

/* include/bp_model.svh */
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

// shadow tables
logic [1:0]                m_ctr      [0:2**bh_idx_bits-1];
logic [1:0]                m_ctr_next [0:2**bh_idx_bits-1];
bp_pkg::pc_t               m_tgt      [0:2**bh_idx_bits-1];

logic                      exp_rollback_en;
logic [rob_idx_bits-1:0]   exp_rob;
logic [fl_idx_bits-1:0]    exp_fl;
logic [lsq_idx_bits-1:0]   exp_sq;
logic [lsq_idx_bits-1:0]   exp_lq;
logic [1:0]                exp_take;
logic [1:0]                exp_slot_valid;
bp_pkg::pc_t               exp_redirect;
logic                      exp_btb_we;
logic [bh_idx_bits-1:0]    exp_btb_idx;
bp_pkg::pc_t               exp_btb_tgt;

task automatic model_reset();
  for (int k = 0; k < 2**bh_idx_bits; k++) begin
    m_ctr[k] = bp_pkg::bht_reset_val;
    m_tgt[k] = bp_pkg::btb_reset_val;
  end
endtask

task automatic model_eval();
  bp_pkg::pc_t             nxt [2];
  bp_pkg::pc_t             tgt [2];
  bp_pkg::pc_t             rb_pc;
  logic [rob_idx_bits-1:0] bd  [2];
  logic [rob_idx_bits-1:0] ldd [2];
  logic [1:0]              misp;
  logic [1:0]              pred;
  logic [bh_idx_bits-1:0]  idx;
  logic                    cond;
  logic                    uncond;
  logic                    br_win;
  logic                    ld_win;
  int                      bw;
  int                      lw;
  for (int i = 0; i < 2; i++) begin
    nxt[i]  = br_taken[i] ? br_target[i] : br_pc[i] + 64'd4;
    misp[i] = br_done[i] && (nxt[i] != br_pred_target[i]);
    bd[i]   = rob_tail_idx - br_rob_idx[i]; // age, wraps mod rob size
    ldd[i]  = rob_tail_idx - ld_rob_idx[i];
  end
  bw = 0;
  if (misp == 2'b10 || (misp == 2'b11 && bd[1] > bd[0])) bw = 1;
  lw = 0;
  if (ld_violate == 2'b10 || (ld_violate == 2'b11 && ldd[1] > ldd[0])) lw = 1;
  br_win = (misp != 2'b00) && (ld_violate == 2'b00 || bd[bw] >= ldd[lw]);
  ld_win = (ld_violate != 2'b00) && !br_win;
  exp_rollback_en = br_win || ld_win;
  {rb_pc, exp_rob, exp_fl, exp_sq, exp_lq} = '0;
  if (br_win) begin
    {rb_pc, exp_rob, exp_fl} = {nxt[bw], br_rob_idx[bw], br_fl_idx[bw]};
    {exp_sq, exp_lq} = {br_sq_idx[bw], br_lq_idx[bw]};
  end else if (ld_win) begin
    {rb_pc, exp_rob, exp_fl} = {ld_replay_pc[lw], ld_rob_idx[lw], ld_fl_idx[lw]};
    {exp_sq, exp_lq} = {ld_sq_idx[lw], ld_lq_idx[lw]};
  end
  m_ctr_next = m_ctr;
  for (int i = 0; i < 2; i++) begin
    idx = br_pc[i][bh_idx_bits+1:2];
    if (br_done[i] && !ld_win) begin
      if (br_taken[i] && m_ctr_next[idx] != 2'b11) begin
        m_ctr_next[idx] = m_ctr_next[idx] + 2'd1;
      end else if (!br_taken[i] && m_ctr_next[idx] != 2'b00) begin
        m_ctr_next[idx] = m_ctr_next[idx] - 2'd1;
      end
    end
  end
  exp_btb_we  = br_win && br_taken[bw];
  exp_btb_idx = br_pc[bw][bh_idx_bits+1:2];
  exp_btb_tgt = br_target[bw];
  for (int i = 0; i < 2; i++) begin
    idx    = fetch_pc[i][bh_idx_bits+1:2];
    cond   = 1'b0;
    uncond = 1'b0;
    case (fetch_inst[i][31:26])
      bp_pkg::blbc_op, bp_pkg::beq_op, bp_pkg::blt_op, bp_pkg::ble_op,
      bp_pkg::blbs_op, bp_pkg::bne_op, bp_pkg::bge_op, bp_pkg::bgt_op: cond = 1'b1;
      bp_pkg::br_op, bp_pkg::bsr_op, bp_pkg::jsr_grp_op:              uncond = 1'b1;
      default:                                                        cond = 1'b0;
    endcase
    pred[i] = fetch_valid[i] && (uncond || (cond && m_ctr_next[idx][1]));
    tgt[i]  = (exp_btb_we && exp_btb_idx == idx) ? exp_btb_tgt : m_tgt[idx];
  end
  if (exp_rollback_en) begin
    exp_take       = 2'b11;
    exp_slot_valid = 2'b00;
    exp_redirect   = rb_pc;
  end else begin
    exp_take       = pred;
    exp_slot_valid = {fetch_valid[1] && !pred[0], fetch_valid[0]};
    exp_redirect   = pred[0] ? tgt[0] : (pred[1] ? tgt[1] : fetch_next_pc);
  end
endtask

// tables take the update at the coming edge
task automatic model_commit();
  m_ctr = m_ctr_next;
  if (exp_btb_we) m_tgt[exp_btb_idx] = exp_btb_tgt;
endtask

`endif

/* test/tb_bp.sv */
`timescale 1ns/1ps

module tb_bp;

  localparam int bh_idx_bits  = 5;
  localparam int rob_idx_bits = 5;
  localparam int fl_idx_bits  = 6;
  localparam int lsq_idx_bits = 3;
  localparam int num_cycles   = 2000;

  logic                          clock;
  logic                          reset;
  bp_pkg::pc_t [1:0]             fetch_pc;
  bp_pkg::inst_t [1:0]           fetch_inst;
  logic [1:0]                    fetch_valid;
  bp_pkg::pc_t                   fetch_next_pc;
  logic [rob_idx_bits-1:0]       rob_tail_idx;
  logic [1:0]                    br_done;
  logic [1:0]                    br_taken;
  bp_pkg::pc_t [1:0]             br_pc;
  bp_pkg::pc_t [1:0]             br_pred_target;
  bp_pkg::pc_t [1:0]             br_target;
  logic [1:0][rob_idx_bits-1:0]  br_rob_idx;
  logic [1:0][fl_idx_bits-1:0]   br_fl_idx;
  logic [1:0][lsq_idx_bits-1:0]  br_sq_idx;
  logic [1:0][lsq_idx_bits-1:0]  br_lq_idx;
  logic [1:0]                    ld_violate;
  bp_pkg::pc_t [1:0]             ld_replay_pc;
  logic [1:0][rob_idx_bits-1:0]  ld_rob_idx;
  logic [1:0][fl_idx_bits-1:0]   ld_fl_idx;
  logic [1:0][lsq_idx_bits-1:0]  ld_sq_idx;
  logic [1:0][lsq_idx_bits-1:0]  ld_lq_idx;
  logic                          rollback_en;
  logic [rob_idx_bits-1:0]       rollback_rob_idx;
  logic [fl_idx_bits-1:0]        rollback_fl_idx;
  logic [lsq_idx_bits-1:0]       rollback_sq_idx;
  logic [lsq_idx_bits-1:0]       rollback_lq_idx;
  logic [1:0]                    take_branch;
  bp_pkg::pc_t                   redirect_pc;
  logic [1:0]                    slot_valid;
  integer                        seed;

  `include "bp_model.svh"

  bp_top u_dut (.*);

  always #50 clock = ~clock;

  task automatic end_with_failure();
    $display("TB FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_pc(input string name, input bp_pkg::pc_t got, input bp_pkg::pc_t exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_idx(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      end_with_failure();
    end
  endtask

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  // small pool, bit 7 aliases onto the same table index
  function automatic bp_pkg::pc_t pick_pc();
    logic [31:0] r;
    bp_pkg::pc_t p;
    r = rand_word();
    p = 64'h1000;
    p[4:2] = r[2:0];
    p[7] = r[3];
    return p;
  endfunction

  function automatic bp_pkg::inst_t pick_inst();
    logic [31:0] r;
    bp_pkg::opcode_t op;
    r = rand_word();
    case (r[4:2])
      3'd0: op = bp_pkg::blbc_op;
      3'd1: op = bp_pkg::beq_op;
      3'd2: op = bp_pkg::blt_op;
      3'd3: op = bp_pkg::ble_op;
      3'd4: op = bp_pkg::blbs_op;
      3'd5: op = bp_pkg::bne_op;
      3'd6: op = bp_pkg::bge_op;
      default: op = bp_pkg::bgt_op;
    endcase
    if (r[1:0] == 2'd2) op = r[6] ? bp_pkg::jsr_grp_op : (r[5] ? bp_pkg::bsr_op : bp_pkg::br_op);
    if (r[1:0] == 2'd3) op = r[31:26]; // mostly non-branch
    return {op, r[25:0]};
  endfunction

  // quiet cycle with a conditional branch fetched in slot 0
  task automatic drive_idle();
    {fetch_pc, fetch_inst, fetch_next_pc, rob_tail_idx} = '0;
    {br_done, br_taken, br_pc, br_pred_target, br_target} = '0;
    {br_rob_idx, br_fl_idx, br_sq_idx, br_lq_idx} = '0;
    {ld_violate, ld_replay_pc, ld_rob_idx, ld_fl_idx, ld_sq_idx, ld_lq_idx} = '0;
    fetch_valid   = 2'b01;
    fetch_pc[0]   = 64'h1010;
    fetch_inst[0] = {bp_pkg::beq_op, 26'h0};
    fetch_next_pc = 64'h1018;
  endtask

  task automatic drive_training(input logic taken);
    drive_idle();
    br_done[0]        = 1'b1;
    br_taken[0]       = taken;
    br_pc[0]          = 64'h1010;
    br_target[0]      = 64'h1800;
    br_pred_target[0] = taken ? 64'h1800 : 64'h1014; // correctly predicted
  endtask

  task automatic drive_random();
    logic [31:0] r;
    logic [31:0] q;
    bp_pkg::pc_t actual;
    r = rand_word();
    rob_tail_idx = r[rob_idx_bits-1:0];
    for (int i = 0; i < 2; i++) begin
      r = rand_word();
      q = rand_word();
      fetch_pc[i]    = pick_pc();
      fetch_inst[i]  = pick_inst();
      fetch_valid[i] = r[10] | r[11];
      br_pc[i]       = pick_pc();
      br_done[i]     = (r % 32'd10) < 32'd3;
      br_taken[i]    = r[8];
      br_target[i]   = 64'h2000;
      br_target[i][9:2] = r[19:12];
      actual = br_taken[i] ? br_target[i] : br_pc[i] + 64'd4;
      br_pred_target[i] = r[9] ? actual : actual ^ 64'h40;
      br_rob_idx[i]  = rob_tail_idx - {2'b00, r[22:20]}; // narrow spread, many ties
      br_fl_idx[i]   = r[28:23];
      br_sq_idx[i]   = q[2:0];
      br_lq_idx[i]   = q[5:3];
      ld_violate[i]  = (q % 32'd10) < 32'd3;
      ld_replay_pc[i] = 64'h3000;
      ld_replay_pc[i][9:2] = q[13:6];
      ld_rob_idx[i]  = rob_tail_idx - {2'b00, q[16:14]};
      ld_fl_idx[i]   = q[22:17];
      ld_sq_idx[i]   = q[25:23];
      ld_lq_idx[i]   = q[28:26];
    end
    fetch_next_pc = fetch_pc[1] + 64'd4;
  endtask

  task automatic check_outputs();
    check_flag("rollback_en", rollback_en, exp_rollback_en);
    check_idx("rollback_rob_idx", 8'(rollback_rob_idx), 8'(exp_rob));
    check_idx("rollback_fl_idx", 8'(rollback_fl_idx), 8'(exp_fl));
    check_idx("rollback_sq_idx", 8'(rollback_sq_idx), 8'(exp_sq));
    check_idx("rollback_lq_idx", 8'(rollback_lq_idx), 8'(exp_lq));
    check_flag("take_branch[0]", take_branch[0], exp_take[0]);
    check_flag("take_branch[1]", take_branch[1], exp_take[1]);
    check_flag("slot_valid[0]", slot_valid[0], exp_slot_valid[0]);
    check_flag("slot_valid[1]", slot_valid[1], exp_slot_valid[1]);
    check_pc("redirect_pc", redirect_pc, exp_redirect);
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  // sample just before the edge, then step the model
  task automatic settle_and_check();
    #89;
    model_eval();
    check_outputs();
    model_commit();
  endtask

  initial begin
    #(2 * num_cycles * 100);
    $display("timeout, the run did not finish in time");
    end_with_failure();
  end

  initial begin
    seed  = 32'ha25e;
    clock = 1'b0;
    reset = 1'b1;
    drive_idle();
    model_reset();
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    settle_and_check();
    check_flag("take_branch[0]", take_branch[0], 1'b0); // counters start weakly not taken
    for (int n = 0; n < 4; n++) begin
      next_cycle();
      drive_training(1'b1);
      settle_and_check();
    end
    check_flag("take_branch[0]", take_branch[0], 1'b1);
    for (int n = 0; n < 4; n++) begin
      next_cycle();
      drive_training(1'b0);
      settle_and_check();
    end
    check_flag("take_branch[0]", take_branch[0], 1'b0);
    next_cycle();
    drive_training(1'b1);
    br_pred_target[0] = 64'h1014; // wrong path forces a rollback and a target write
    settle_and_check();
    next_cycle();
    drive_idle();
    fetch_inst[0] = {bp_pkg::br_op, 26'h0};
    settle_and_check();
    check_pc("redirect_pc", redirect_pc, 64'h1800);
    for (int n = 0; n < num_cycles; n++) begin
      next_cycle();
      drive_random();
      settle_and_check();
    end
    $display("TB PASSED");
    $finish;
  end

endmodule
